// ==== build.f ====
hdl/prefetch_pkg.sv
hdl/fetch_fsm.sv
hdl/fetch_fifo.sv
hdl/prefetch_buffer.sv
tests/tb_instr_mem.sv
tests/tb_prefetch_buffer.sv

// ==== hdl/fetch_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_fifo (
  input  wire                       clk,
  input  wire                       rst_n,
  // flush that takes effect in the next cycle
  input  wire                       clear_i,
  // push side from the fetch fsm
  input  wire                       push_valid_i,
  input  wire prefetch_pkg::addr_t  push_addr_i,
  input  wire prefetch_pkg::instr_t push_rdata_i,
  output logic                      can_accept_o,
  // core side
  output logic                      out_valid_o,
  input  wire                       pop_ready_i,
  output prefetch_pkg::addr_t       out_addr_o,
  output prefetch_pkg::instr_t      out_rdata_o
);

  import prefetch_pkg::*;

  // entry 0 is the head and entries shift down on a pop
  addr_t     addr_q  [FETCH_FIFO_DEPTH];
  addr_t     addr_d  [FETCH_FIFO_DEPTH];
  instr_t    rdata_q [FETCH_FIFO_DEPTH];
  instr_t    rdata_d [FETCH_FIFO_DEPTH];
  fifo_cnt_t fill_q;
  fifo_cnt_t fill_d;
  fifo_cnt_t wr_idx;

  logic empty;
  logic push_en;
  logic pop_en;
  logic pop_stored;
  logic store_en;

  //////////////////////////////
  // handshake
  //////////////////////////////

  // a clear swallows the push of the same cycle
  assign push_en = push_valid_i & ~clear_i;
  assign empty   = (fill_q == '0);

  // bypass when empty so a word is visible in its rvalid cycle
  assign out_valid_o = ~empty | push_en;
  assign out_addr_o  = empty ? push_addr_i  : addr_q[0];
  assign out_rdata_o = empty ? push_rdata_i : rdata_q[0];

  assign pop_en     = out_valid_o & pop_ready_i;
  // pop of a stored entry rather than the bypassed word
  assign pop_stored = pop_en & ~empty;
  // bypassed word taken at once needs no storage
  assign store_en   = push_en & ~(empty & pop_en);

  // free slot right behind the remaining entries
  assign wr_idx = fill_q - fifo_cnt_t'(pop_stored);

  // room for one more response after the push of this cycle
  assign can_accept_o = (int'(fill_q) + int'(push_en)) < FETCH_FIFO_DEPTH;

  //////////////////////////////
  // storage update
  //////////////////////////////

  always_comb begin
    addr_d  = addr_q;
    rdata_d = rdata_q;
    if (pop_stored) begin
      for (int i = 0; i < FETCH_FIFO_DEPTH - 1; i++) begin
        addr_d[i]  = addr_q[i+1];
        rdata_d[i] = rdata_q[i+1];
      end
    end
    if (store_en) begin
      addr_d[wr_idx]  = push_addr_i;
      rdata_d[wr_idx] = push_rdata_i;
    end
  end

  always_comb begin
    if (clear_i) begin
      fill_d = '0;
    end else begin
      fill_d = fill_q + fifo_cnt_t'(store_en) - fifo_cnt_t'(pop_stored);
    end
  end

  // entry payload registers
  always_ff @(posedge clk) begin
    addr_q  <= addr_d;
    rdata_q <= rdata_d;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fill_q <= '0;
    end else begin
      fill_q <= fill_d;
    end
  end

  // fsm only requests when the response has a free slot
  a_no_push_when_full : assert property (
    @(posedge clk) disable iff (!rst_n)
    push_en |-> (int'(fill_q) < FETCH_FIFO_DEPTH)
  );

endmodule

`default_nettype wire

// ==== hdl/fetch_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_fsm (
  input  wire                   clk,
  input  wire                   rst_n,
  // core side
  input  wire                   req_i,
  input  wire                   branch_i,
  input  wire prefetch_pkg::addr_t  branch_addr_i,
  // room in the fetch fifo for one more response
  input  wire                   fifo_can_accept_i,
  // instruction memory
  output logic                  instr_req_o,
  output prefetch_pkg::addr_t   instr_addr_o,
  input  wire                   instr_gnt_i,
  input  wire prefetch_pkg::instr_t instr_rdata_i,
  input  wire                   instr_rvalid_i,
  // towards the fetch fifo
  output logic                  push_valid_o,
  output prefetch_pkg::addr_t   push_addr_o,
  output prefetch_pkg::instr_t  push_rdata_o,
  // status
  output logic                  idle_o
);

  import prefetch_pkg::*;

  // one outstanding request at most
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_GNT,
    ST_WAIT_RVALID,
    ST_WAIT_ABORTED
  } state_e;

  state_e state_q;
  state_e state_d;

  // address of the last request sent (or of the pending target)
  addr_t last_addr_q;
  addr_t fetch_addr;
  addr_t branch_target;
  logic  addr_load;
  logic  issue_ok;

  //////////////////////////////
  // address generation
  //////////////////////////////

  // requests are always word aligned
  assign branch_target = {branch_addr_i[ADDR_W-1:2], 2'b00};

  // next sequential word
  assign fetch_addr = last_addr_q + FETCH_STRIDE;

  // a branch may always issue, the fifo is cleared with it
  assign issue_ok = req_i & (fifo_can_accept_i | branch_i);

  //////////////////////////////
  // next state
  //////////////////////////////

  always_comb begin
    state_d      = state_q;
    instr_req_o  = 1'b0;
    addr_load    = 1'b0;
    push_valid_o = 1'b0;
    // branch target wins over the sequential address
    instr_addr_o = branch_i ? branch_target : fetch_addr;

    case (state_q)
      // nothing in flight
      ST_IDLE: begin
        if (issue_ok) begin
          instr_req_o = 1'b1;
          addr_load   = 1'b1;
          state_d     = instr_gnt_i ? ST_WAIT_RVALID : ST_WAIT_GNT;
        end
      end

      // request raised, grant still missing
      ST_WAIT_GNT: begin
        instr_req_o = 1'b1;
        if (branch_i) begin
          // swap the pending address for the target
          addr_load = 1'b1;
        end else begin
          instr_addr_o = last_addr_q;
        end
        if (instr_gnt_i) begin
          state_d = ST_WAIT_RVALID;
        end
      end

      // granted, data pending
      ST_WAIT_RVALID: begin
        // same-cycle branch kills this push through the fifo clear
        push_valid_o = instr_rvalid_i;
        if (instr_rvalid_i) begin
          if (issue_ok) begin
            // chain the next request behind the response
            instr_req_o = 1'b1;
            addr_load   = 1'b1;
            state_d     = instr_gnt_i ? ST_WAIT_RVALID : ST_WAIT_GNT;
          end else begin
            state_d = ST_IDLE;
          end
        end else if (branch_i) begin
          // response in flight belongs to the old path
          addr_load = 1'b1;
          state_d   = ST_WAIT_ABORTED;
        end
      end

      // stale response pending, target held in last_addr_q
      ST_WAIT_ABORTED: begin
        if (branch_i) begin
          addr_load = 1'b1;
        end else begin
          instr_addr_o = last_addr_q;
        end
        // drop the stale data, then go for the target
        // core keeps req_i high across a redirect
        if (instr_rvalid_i) begin
          instr_req_o = 1'b1;
          state_d     = instr_gnt_i ? ST_WAIT_RVALID : ST_WAIT_GNT;
        end
      end

      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= ST_IDLE;
      last_addr_q <= '0;
    end else begin
      state_q <= state_d;
      if (addr_load) begin
        last_addr_q <= instr_addr_o;
      end
    end
  end

  //////////////////////////////
  // fifo push and status
  //////////////////////////////

  // response always belongs to the last requested address
  assign push_addr_o  = last_addr_q;
  assign push_rdata_o = instr_rdata_i;

  assign idle_o = (state_q == ST_IDLE);

  // memory side must see a steady address until the grant
  a_addr_stable_until_gnt : assert property (
    @(posedge clk) disable iff (!rst_n)
    instr_req_o && !instr_gnt_i |=>
      instr_req_o && (branch_i || $stable(instr_addr_o))
  );

endmodule

`default_nettype wire

// ==== hdl/prefetch_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module prefetch_buffer (
  input  wire                       clk,
  input  wire                       rst_n,
  // core fetch stage
  input  wire                       req_i,
  input  wire                       branch_i,
  input  wire prefetch_pkg::addr_t  addr_i,
  input  wire                       ready_i,
  output logic                      valid_o,
  output prefetch_pkg::instr_t      rdata_o,
  output prefetch_pkg::addr_t       addr_o,
  // instruction memory
  output logic                      instr_req_o,
  output prefetch_pkg::addr_t       instr_addr_o,
  input  wire                       instr_gnt_i,
  input  wire prefetch_pkg::instr_t instr_rdata_i,
  input  wire                       instr_rvalid_i,
  // error response, not handled yet
  input  wire                       instr_err_i,
  // status
  output logic                      busy_o
);

  import prefetch_pkg::*;

  // fsm to fifo
  logic   push_valid;
  addr_t  push_addr;
  instr_t push_rdata;
  logic   fifo_can_accept;
  logic   fsm_idle;

  //////////////////////////////
  // memory side fsm
  //////////////////////////////

  fetch_fsm u_fetch_fsm (
    .clk               (clk),
    .rst_n             (rst_n),
    .req_i             (req_i),
    .branch_i          (branch_i),
    .branch_addr_i     (addr_i),
    .fifo_can_accept_i (fifo_can_accept),
    .instr_req_o       (instr_req_o),
    .instr_addr_o      (instr_addr_o),
    .instr_gnt_i       (instr_gnt_i),
    .instr_rdata_i     (instr_rdata_i),
    .instr_rvalid_i    (instr_rvalid_i),
    .push_valid_o      (push_valid),
    .push_addr_o       (push_addr),
    .push_rdata_o      (push_rdata),
    .idle_o            (fsm_idle)
  );

  //////////////////////////////
  // core side fifo
  //////////////////////////////

  // a branch flushes every buffered word of the old path
  fetch_fifo u_fetch_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .clear_i      (branch_i),
    .push_valid_i (push_valid),
    .push_addr_i  (push_addr),
    .push_rdata_i (push_rdata),
    .can_accept_o (fifo_can_accept),
    .out_valid_o  (valid_o),
    .pop_ready_i  (ready_i),
    .out_addr_o   (addr_o),
    .out_rdata_o  (rdata_o)
  );

  // busy while anything is in flight or about to be
  assign busy_o = ~fsm_idle | instr_req_o;

endmodule

`default_nettype wire

// ==== hdl/prefetch_pkg.sv ====
`default_nettype none

package prefetch_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  // one instruction word per fetch, byte addressed
  localparam int ADDR_W  = 32;
  localparam int INSTR_W = 32;

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [INSTR_W-1:0] instr_t;

  //////////////////////////////
  // fetch parameters
  //////////////////////////////

  // entries of the fetch fifo
  localparam int FETCH_FIFO_DEPTH = 3;

  // sequential fetch advances one word
  localparam addr_t FETCH_STRIDE = addr_t'(4);

  // fill counter must reach FETCH_FIFO_DEPTH itself
  localparam int FIFO_CNT_W = $clog2(FETCH_FIFO_DEPTH + 1);

  typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;

endpackage

`default_nettype wire

// ==== tests/prefetch_input.txt ====
# name target_hex words max_grant_delay max_rvalid_delay ready_duty_percent
# each line opens with a branch to its target, memory data is the inverse address
seq_zero_wait 00001000 24 0 0 100
seq_grant_wait 00002000 24 4 0 100
seq_rvalid_wait 00003000 24 0 4 100
unaligned_target 00004007 16 2 2 100
mixed_delays 0000a10c 32 3 3 75
backpressure_light 00010000 32 1 1 50
backpressure_heavy 00020004 32 2 2 15
slow_memory 0003fff0 20 8 8 60
stall_fast_mem 00050000 24 0 0 10
wrap_high fffffff0 12 1 2 80
midflight_short 00060002 3 3 3 90
midflight_again 00070001 2 5 5 100
back_to_start 00001000 16 1 1 40

// ==== tests/tb_instr_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_instr_mem #(
  parameter logic [31:0] SEED = 32'h116a_6bdf
) (
  input  wire         clk,
  input  wire         rst_n,
  input  wire         instr_req_i,
  input  wire  [31:0] instr_addr_i,
  output logic        instr_gnt_o,
  output logic [31:0] instr_rdata_o,
  output logic        instr_rvalid_o,
  // upper bounds of the random delays, in cycles
  input  wire  [31:0] max_gnt_dly_i,
  input  wire  [31:0] max_rv_dly_i,
  output int          err_cnt_o
);

  // bus state of the cycle that just ended, sampled mid cycle
  logic        rst_s = 1'b0;
  logic        req_s = 1'b0;
  logic        gnt_s = 1'b0;
  logic        rv_s = 1'b0;
  logic [31:0] addr_s = '0;
  logic [31:0] rnd = SEED;
  // one granted request waiting for its rvalid
  logic        pend = 1'b0;
  logic [31:0] pend_addr = '0;
  int unsigned gnt_wait = 0;
  int unsigned rv_wait = 0;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  initial begin
    instr_gnt_o    = 1'b0;
    instr_rdata_o  = '0;
    instr_rvalid_o = 1'b0;
    err_cnt_o      = 0;
  end

  //////////////////////////////
  // bus model, new values 0.5 ns after the edge
  //////////////////////////////

  always begin
    @(posedge clk);
    #0.5;
    if (!rst_s) begin
      pend     = 1'b0;
      gnt_wait = 0;
      rv_wait  = 0;
    end else begin
      // response delivered last cycle
      if (rv_s) begin
        pend = 1'b0;
      end
      assert (!(req_s && pend)) else begin
        $display("request at %0t while a response is still outstanding", $time);
        err_cnt_o++;
      end
      if (req_s && gnt_s) begin
        pend      = 1'b1;
        pend_addr = addr_s;
        rnd       = xorshift32(rnd);
        rv_wait   = rnd % (max_rv_dly_i + 1);
        rnd       = xorshift32(rnd);
        gnt_wait  = rnd % (max_gnt_dly_i + 1);
      end else begin
        if (pend && rv_wait != 0) begin
          rv_wait--;
        end
        // grant delay only runs down while a request waits
        if (req_s && gnt_wait != 0) begin
          gnt_wait--;
        end
      end
    end
    rnd            = xorshift32(rnd);
    instr_gnt_o    = rst_s && (gnt_wait == 0);
    instr_rvalid_o = pend && (rv_wait == 0);
    // inverse address as data, noise outside rvalid
    instr_rdata_o  = instr_rvalid_o ? ~pend_addr : rnd;
    #1.0;
    rst_s  = rst_n;
    req_s  = instr_req_i;
    gnt_s  = instr_gnt_o;
    rv_s   = instr_rvalid_o;
    addr_s = instr_addr_i;
  end

endmodule

`default_nettype wire

// ==== tests/tb_prefetch_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_prefetch_buffer;

  import prefetch_pkg::*;

  localparam logic [31:0] SEED          = 32'h116a_6bdf;
  localparam int          SCEN_TIMEOUT  = 3000;
  localparam int          DRAIN_TIMEOUT = 200;

  logic   clk = 1'b0;
  logic   rst_n, req, branch, ready, valid, busy;
  addr_t  target, addr, instr_addr;
  instr_t rdata, instr_rdata;
  logic   instr_req, instr_gnt, instr_rvalid, instr_err;
  int     mem_errs;

  // one scenario line of the input file
  logic [8*32-1:0]  name;
  logic [8*160-1:0] line;
  logic [31:0]      tgt, words, max_gnt, max_rv, duty;

  int     fd, nscan, errors, tests, bad_tests, consumed, cycles;
  addr_t  exp_addr, prev_addr;
  instr_t prev_rdata;
  logic   prev_valid, prev_fire, prev_branch;
  // a granted request whose rvalid has not been seen yet
  logic   outstanding;
  logic [31:0] rnd;

  always #2 clk = ~clk;

  prefetch_buffer dut0 (
    .clk (clk), .rst_n (rst_n), .req_i (req), .branch_i (branch), .addr_i (target),
    .ready_i (ready), .valid_o (valid), .rdata_o (rdata), .addr_o (addr),
    .instr_req_o (instr_req), .instr_addr_o (instr_addr), .instr_gnt_i (instr_gnt),
    .instr_rdata_i (instr_rdata), .instr_rvalid_i (instr_rvalid),
    .instr_err_i (instr_err), .busy_o (busy)
  );

  tb_instr_mem #(.SEED(SEED)) u_mem (
    .clk (clk), .rst_n (rst_n), .instr_req_i (instr_req), .instr_addr_i (instr_addr),
    .instr_gnt_o (instr_gnt), .instr_rdata_o (instr_rdata), .instr_rvalid_o (instr_rvalid),
    .max_gnt_dly_i (max_gnt), .max_rv_dly_i (max_rv), .err_cnt_o (mem_errs)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string sig, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("mismatch at %0t: %0s expected %h got %h", $time, sig, exp, act);
      errors++;
    end
  endtask

  //////////////////////////////
  // output checks once per cycle
  //////////////////////////////

  task automatic check_outputs();
    logic fire;
    fire = valid && ready;
    // a stalled word stays put unless a branch flushed it
    if (prev_valid && !prev_fire && !prev_branch) begin
      assert (valid) else begin
        $display("valid_o dropped at %0t without a transfer", $time);
        errors++;
      end
      if (valid) begin
        check_value("addr_o", prev_addr, addr);
        check_value("rdata_o", prev_rdata, rdata);
      end
    end
    if (fire) begin
      check_value("addr_o", exp_addr, addr);
      check_value("rdata_o", ~exp_addr, rdata);
      exp_addr = exp_addr + 32'd4;
      consumed++;
    end
    // busy while a request is raised or a granted one still waits for its data
    check_value("busy_o", {31'd0, instr_req || outstanding}, {31'd0, busy});
    if (instr_req && instr_gnt) begin
      outstanding = 1'b1;
    end else if (instr_rvalid) begin
      outstanding = 1'b0;
    end
    prev_valid  = valid;
    prev_fire   = fire;
    prev_branch = branch;
    prev_addr   = addr;
    prev_rdata  = rdata;
  endtask

  // drive 0.5 ns after the edge and sample 1 ns later when all is settled
  task automatic run_cycle(input logic req_lvl, input logic br, input logic rdy);
    @(posedge clk);
    #0.5;
    req    = req_lvl;
    branch = br;
    target = br ? tgt : rnd;
    ready  = rdy;
    #1.0;
    check_outputs();
  endtask

  task automatic report_test(input logic [8*32-1:0] tname, input int err_base);
    int n;
    n = errors + mem_errs - err_base;
    tests++;
    if (n != 0) begin
      bad_tests++;
    end
    $display("%0s: %0d words, %0d errors", tname, consumed, n);
  endtask

  task automatic run_scenario();
    int base;
    base     = errors + mem_errs;
    consumed = 0;
    cycles   = 0;
    // target is fetched word aligned
    exp_addr = {tgt[31:2], 2'b00};
    run_cycle(1'b1, 1'b1, 1'b0);
    while (consumed < words && cycles < SCEN_TIMEOUT) begin
      rnd = xorshift32(rnd);
      run_cycle(1'b1, 1'b0, (rnd % 100) < duty);
      cycles++;
    end
    if (consumed < words) begin
      $display("%0s: timed out with %0d of %0d words", name, consumed, words);
      errors++;
    end
    report_test(name, base);
  endtask

  task automatic drain_buffer();
    int base;
    base     = errors + mem_errs;
    consumed = 0;
    cycles   = 0;
    run_cycle(1'b0, 1'b0, 1'b1);
    while ((busy || valid) && cycles < DRAIN_TIMEOUT) begin
      run_cycle(1'b0, 1'b0, 1'b1);
      cycles++;
    end
    if (busy || valid) begin
      $display("busy_o or valid_o still high after %0d drain cycles", cycles);
      errors++;
    end
    report_test("drain", base);
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    rst_n = 1'b0;
    req = 1'b0;
    branch = 1'b0;
    target = '0;
    ready = 1'b0;
    instr_err = 1'b0;
    {tgt, words, max_gnt, max_rv, duty} = '0;
    {errors, tests, bad_tests, consumed, cycles} = '0;
    {prev_valid, prev_fire, prev_branch, prev_addr, prev_rdata, exp_addr} = '0;
    outstanding = 1'b0;
    rnd = SEED;
    repeat (8) @(posedge clk);
    #0.5;
    rst_n = 1'b1;
    #1.0;
    check_value("valid_o", 32'd0, {31'd0, valid});
    check_value("instr_req_o", 32'd0, {31'd0, instr_req});
    check_value("busy_o", 32'd0, {31'd0, busy});
    report_test("reset", 0);
    fd = $fopen("tests/prefetch_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the scenario file tests/prefetch_input.txt");
      errors++;
    end else begin
      // comment lines do not scan all six columns
      while ($fgets(line, fd) != 0) begin
        nscan = $sscanf(line, "%s %h %d %d %d %d", name, tgt, words, max_gnt, max_rv, duty);
        if (nscan == 6) begin
          run_scenario();
        end
      end
      $fclose(fd);
    end
    if (tests < 2) begin
      $display("no scenario lines found in the scenario file");
      errors++;
    end
    drain_buffer();
    $display("summary: %0d tests, %0d with errors, %0d errors", tests, bad_tests,
             errors + mem_errs);
    if (errors == 0 && mem_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
